// ==== common/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath and instruction widths
`define XLEN        64
`define ILEN        32

// integer register file
`define REG_COUNT   32
`define REG_IDX_W   5

// first address fetched after reset
`define RESET_PC    64'h0000_0000_8000_0000

`endif

// ==== common/core_pkg.sv ====
`default_nettype none
`include "core_config.svh"

package core_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B          // lui
    } alu_op_e;

    // one instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [`REG_IDX_W-1:0] rs2;
            logic [`REG_IDX_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [`REG_IDX_W-1:0] rd;
            opcode_e               opcode;
        } r_fmt;
        struct packed {
            logic [11:0]           imm;
            logic [`REG_IDX_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [`REG_IDX_W-1:0] rd;
            opcode_e               opcode;
        } i_fmt;
        struct packed {
            logic                  imm12;
            logic [5:0]            imm10_5;
            logic [`REG_IDX_W-1:0] rs2;
            logic [`REG_IDX_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [3:0]            imm4_1;
            logic                  imm11;
            opcode_e               opcode;
        } b_fmt;
        struct packed {
            logic [19:0]           imm31_12;
            logic [`REG_IDX_W-1:0] rd;
            opcode_e               opcode;
        } u_fmt;
        struct packed {
            logic                  imm20;
            logic [9:0]            imm10_1;
            logic                  imm11;
            logic [7:0]            imm19_12;
            logic [`REG_IDX_W-1:0] rd;
            opcode_e               opcode;
        } j_fmt;
    } instr_u;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        instr_u           instr;
    } if_id_t;

    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        logic [`XLEN-1:0]      rs1_val;
        logic [`XLEN-1:0]      rs2_val;
        logic [`REG_IDX_W-1:0] rs1_idx;
        logic [`REG_IDX_W-1:0] rs2_idx;
        logic [`XLEN-1:0]      imm;
        logic [`REG_IDX_W-1:0] rd;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic                  writes_rd;
        logic                  is_branch;
        logic [2:0]            funct3;    // beq vs bne
        logic                  is_jal;
    } id_ex_t;

    typedef struct packed {
        logic [`XLEN-1:0]      pc;
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      result;
        logic                  writes_rd;
    } ex_wb_t;

endpackage

`default_nettype wire

// ==== rtl/pipeline_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_ctrl (
    input  wire logic clk,
    input  wire logic rst_n_i,
    input  wire logic fetch_fire_i,   // strobe went out last cycle
    input  wire logic redirect_i,
    output logic      id_valid_o,
    output logic      ex_valid_o,
    output logic      wb_valid_o
);

    logic id_kill_q;    // word now in decode was fetched on the wrong path
    logic ex_valid_q;
    logic wb_valid_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_kill_q  <= 1'b0;
            ex_valid_q <= 1'b0;
            wb_valid_q <= 1'b0;
        end else begin
            id_kill_q  <= redirect_i;
            ex_valid_q <= id_valid_o & ~redirect_i;   // squash older fetch
            wb_valid_q <= ex_valid_q;
        end
    end

    assign id_valid_o = fetch_fire_i & ~id_kill_q;
    assign ex_valid_o = ex_valid_q;
    assign wb_valid_o = wb_valid_q;

    a_redirect_from_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_i |-> ex_valid_o);

    // the slot behind a redirect is always flushed
    a_no_back_to_back_redirect: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_i |=> !redirect_i);

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module fetch_unit (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire logic              redirect_i,
    input  wire logic [`XLEN-1:0]  redirect_pc_i,
    output logic                   fetch_req_o,
    output logic [`XLEN-1:0]       fetch_addr_o,
    input  wire logic [`ILEN-1:0]  fetch_instr_i,
    output logic                   fetch_fire_o,
    output core_pkg::if_id_t       if_id_o
);

    logic             req_q;
    logic             fire_q;
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] issued_pc_q;   // pairs with the word returning now

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_q       <= 1'b0;
            fire_q      <= 1'b0;
            pc_q        <= `RESET_PC;
            issued_pc_q <= `RESET_PC;
        end else begin
            req_q  <= 1'b1;          // free running after reset
            fire_q <= req_q;
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (req_q) begin
                pc_q <= pc_q + `XLEN'(4);
            end
            if (req_q) begin
                issued_pc_q <= pc_q;
            end
        end
    end

    assign fetch_req_o   = req_q;
    assign fetch_addr_o  = pc_q;
    assign fetch_fire_o  = fire_q;
    assign if_id_o.pc    = issued_pc_q;
    assign if_id_o.instr = fetch_instr_i;   // memory answers one cycle later

endmodule

`default_nettype wire

// ==== decode/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module inst_decode (
    input  wire logic                   clk,
    input  wire logic                   rst_n_i,
    input  wire core_pkg::if_id_t       if_id_i,
    output logic [`REG_IDX_W-1:0]       rs1_idx_o,
    output logic [`REG_IDX_W-1:0]       rs2_idx_o,
    input  wire logic [`XLEN-1:0]       rs1_data_i,
    input  wire logic [`XLEN-1:0]       rs2_data_i,
    output core_pkg::id_ex_t            id_ex_o
);
    import core_pkg::*;

    instr_u           word;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    id_ex_t           dec;
    id_ex_t           id_ex_q;

    // shared by op and op-imm
    function automatic alu_op_e alu_from_funct(input logic [2:0] funct3, input logic is_sub);
        alu_op_e op;
        case (funct3)
            3'b000:  op = is_sub ? ALU_SUB : ALU_ADD;
            3'b010:  op = ALU_SLT;
            3'b100:  op = ALU_XOR;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign word      = if_id_i.instr;
    assign rs1_idx_o = word.r_fmt.rs1;
    assign rs2_idx_o = word.r_fmt.rs2;

    // sign extended immediates per format
    assign imm_i = {{(`XLEN-12){word.i_fmt.imm[11]}}, word.i_fmt.imm};
    assign imm_b = {{(`XLEN-13){word.b_fmt.imm12}}, word.b_fmt.imm12, word.b_fmt.imm11,
                    word.b_fmt.imm10_5, word.b_fmt.imm4_1, 1'b0};
    assign imm_u = {{(`XLEN-32){word.u_fmt.imm31_12[19]}}, word.u_fmt.imm31_12, 12'b0};
    assign imm_j = {{(`XLEN-21){word.j_fmt.imm20}}, word.j_fmt.imm20, word.j_fmt.imm19_12,
                    word.j_fmt.imm11, word.j_fmt.imm10_1, 1'b0};

    always_comb begin
        dec.pc        = if_id_i.pc;
        dec.rs1_val   = rs1_data_i;
        dec.rs2_val   = rs2_data_i;
        dec.rs1_idx   = word.r_fmt.rs1;
        dec.rs2_idx   = word.r_fmt.rs2;
        dec.imm       = imm_i;
        dec.rd        = word.r_fmt.rd;
        dec.alu_op    = ALU_ADD;      // unknown opcodes end up as a silent addi
        dec.use_imm   = 1'b1;
        dec.writes_rd = 1'b0;
        dec.is_branch = 1'b0;
        dec.funct3    = word.r_fmt.funct3;
        dec.is_jal    = 1'b0;
        case (word.r_fmt.opcode)
            OPC_OP: begin
                dec.use_imm   = 1'b0;
                dec.writes_rd = 1'b1;
                dec.alu_op    = alu_from_funct(word.r_fmt.funct3, word.r_fmt.funct7[5]);
            end
            OPC_OP_IMM: begin
                dec.writes_rd = 1'b1;
                dec.alu_op    = alu_from_funct(word.i_fmt.funct3, 1'b0);
            end
            OPC_LUI: begin
                dec.imm       = imm_u;
                dec.alu_op    = ALU_PASS_B;
                dec.writes_rd = 1'b1;
            end
            OPC_JAL: begin
                dec.imm       = imm_j;
                dec.is_jal    = 1'b1;
                dec.writes_rd = 1'b1;   // link value pc+4
            end
            OPC_BRANCH: begin
                dec.imm       = imm_b;
                dec.use_imm   = 1'b0;
                dec.is_branch = 1'b1;
            end
            default: begin
            end
        endcase
        // x0 targets and branches retire with rd 0
        if (!dec.writes_rd || word.r_fmt.rd == '0) begin
            dec.writes_rd = 1'b0;
            dec.rd        = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q <= dec;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// ==== decode/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module reg_file (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire logic [`REG_IDX_W-1:0] rs1_idx_i,
    input  wire logic [`REG_IDX_W-1:0] rs2_idx_i,
    output logic [`XLEN-1:0]           rs1_data_o,
    output logic [`XLEN-1:0]           rs2_data_o,
    input  wire logic                  wr_en_i,
    input  wire logic [`REG_IDX_W-1:0] wr_idx_i,
    input  wire logic [`XLEN-1:0]      wr_data_i
);

    logic [`XLEN-1:0] regs_q [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (wr_en_i && wr_idx_i != '0) begin
            regs_q[wr_idx_i] <= wr_data_i;
        end
    end

    // write-through so decode sees the retiring value this cycle
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 :
                        (wr_en_i && wr_idx_i == rs1_idx_i) ? wr_data_i : regs_q[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 :
                        (wr_en_i && wr_idx_i == rs2_idx_i) ? wr_data_i : regs_q[rs2_idx_i];

    a_x0_never_written: assert property (@(posedge clk) disable iff (!rst_n_i)
        wr_en_i |-> wr_idx_i != '0);

endmodule

`default_nettype wire

// ==== rtl/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module execute_unit (
    input  wire logic              clk,
    input  wire logic              rst_n_i,
    input  wire logic              ex_valid_i,
    input  wire logic              wb_valid_i,
    input  wire core_pkg::id_ex_t  id_ex_i,
    output core_pkg::ex_wb_t       ex_wb_o,
    output logic                   redirect_o,
    output logic [`XLEN-1:0]       redirect_pc_o
);
    import core_pkg::*;

    ex_wb_t           wb_d;
    ex_wb_t           wb_q;
    logic             fwd_a;
    logic             fwd_b;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    logic             taken;

    // result of the instruction just ahead sits in the writeback register
    assign fwd_a = wb_valid_i && wb_q.writes_rd && id_ex_i.rs1_idx != '0
                   && wb_q.rd == id_ex_i.rs1_idx;
    assign fwd_b = wb_valid_i && wb_q.writes_rd && id_ex_i.rs2_idx != '0
                   && wb_q.rd == id_ex_i.rs2_idx;

    assign op_a    = fwd_a ? wb_q.result : id_ex_i.rs1_val;
    assign rs2_val = fwd_b ? wb_q.result : id_ex_i.rs2_val;
    assign op_b    = id_ex_i.use_imm ? id_ex_i.imm : rs2_val;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // funct3[0] set means bne
    assign taken         = id_ex_i.is_branch && ((op_a == rs2_val) ^ id_ex_i.funct3[0]);
    assign redirect_o    = ex_valid_i && (taken || id_ex_i.is_jal);
    assign redirect_pc_o = id_ex_i.pc + id_ex_i.imm;

    always_comb begin
        wb_d.pc        = id_ex_i.pc;
        wb_d.rd        = id_ex_i.rd;
        wb_d.writes_rd = id_ex_i.writes_rd;
        if (!id_ex_i.writes_rd) begin
            wb_d.result = '0;                          // branches retire zero
        end else if (id_ex_i.is_jal) begin
            wb_d.result = id_ex_i.pc + `XLEN'(4);      // link
        end else begin
            wb_d.result = alu_res;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= wb_d;
        end
    end

    assign ex_wb_o = wb_q;

endmodule

`default_nettype wire

// ==== rtl/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module core_top (
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    output logic                       fetch_req_o,
    output logic [`XLEN-1:0]           fetch_addr_o,
    input  wire logic [`ILEN-1:0]      fetch_instr_i,
    output logic                       retire_valid_o,
    output logic [`XLEN-1:0]           retire_pc_o,
    output logic [`REG_IDX_W-1:0]      retire_rd_o,
    output logic [`XLEN-1:0]           retire_data_o
);
    import core_pkg::*;

    if_id_t                if_id;
    id_ex_t                id_ex;
    ex_wb_t                ex_wb;
    logic                  redirect;
    logic [`XLEN-1:0]      redirect_pc;
    logic                  fetch_fire;
    logic                  ex_valid;
    logic                  wb_valid;
    logic [`REG_IDX_W-1:0] rs1_idx;
    logic [`REG_IDX_W-1:0] rs2_idx;
    logic [`XLEN-1:0]      rs1_data;
    logic [`XLEN-1:0]      rs2_data;

    pipeline_ctrl u_pipeline_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fetch_fire_i (fetch_fire),
        .redirect_i   (redirect),
        .id_valid_o   (),
        .ex_valid_o   (ex_valid),
        .wb_valid_o   (wb_valid)
    );

    fetch_unit u_fetch_unit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .fetch_req_o   (fetch_req_o),
        .fetch_addr_o  (fetch_addr_o),
        .fetch_instr_i (fetch_instr_i),
        .fetch_fire_o  (fetch_fire),
        .if_id_o       (if_id)
    );

    inst_decode u_inst_decode (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .if_id_i    (if_id),
        .rs1_idx_o  (rs1_idx),
        .rs2_idx_o  (rs2_idx),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .id_ex_o    (id_ex)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_en_i    (ex_wb.writes_rd & wb_valid),   // writeback port
        .wr_idx_i   (ex_wb.rd),
        .wr_data_i  (ex_wb.result)
    );

    execute_unit u_execute_unit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ex_valid_i    (ex_valid),
        .wb_valid_i    (wb_valid),
        .id_ex_i       (id_ex),
        .ex_wb_o       (ex_wb),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    // retire straight from the writeback register
    assign retire_valid_o = wb_valid;
    assign retire_pc_o    = ex_wb.pc;
    assign retire_rd_o    = ex_wb.rd;
    assign retire_data_o  = ex_wb.result;

endmodule

`default_nettype wire

// ==== tests/tb_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_config.svh"

module tb_core_top;

    localparam int          PROG_LEN       = 151;              // random body plus closing jal
    localparam int          NUM_RETIRE     = 150;
    localparam int          TIMEOUT_CYCLES = NUM_RETIRE * 3 * 2 + 100;
    localparam logic [31:0] NOP_WORD       = 32'h0000_0013;    // addi x0, x0, 0

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    logic                  fetch_req_o;
    logic [`XLEN-1:0]      fetch_addr_o;
    logic [`ILEN-1:0]      fetch_instr_i = NOP_WORD;
    logic                  retire_valid_o;
    logic [`XLEN-1:0]      retire_pc_o;
    logic [`REG_IDX_W-1:0] retire_rd_o;
    logic [`XLEN-1:0]      retire_data_o;

    logic [31:0]           prog [PROG_LEN];
    logic                  pend_req     = 1'b0;   // strobe seen last cycle
    logic [`XLEN-1:0]      pend_addr    = '0;
    logic                  fetched_once = 1'b0;

    logic [`XLEN-1:0]      model_pc;
    logic [31:0]           model_word;
    logic [`XLEN-1:0]      model_regs [32];
    logic [`XLEN-1:0]      src_a;
    logic [`XLEN-1:0]      src_b;
    logic [`XLEN-1:0]      m_result;
    logic                  m_writes;
    logic [`XLEN-1:0]      exp_next_pc;
    logic [`REG_IDX_W-1:0] exp_rd;
    logic [`XLEN-1:0]      exp_data;
    int                    retire_count = 0;
    int                    cycle_count  = 0;

    core_top u_core_top (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fetch_req_o    (fetch_req_o),
        .fetch_addr_o   (fetch_addr_o),
        .fetch_instr_i  (fetch_instr_i),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    always #50 clk = ~clk;

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] encode_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] encode_b(input logic [12:0] off, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    // add, sub, and, or, xor, slt
    function automatic logic [2:0] pick_funct3(input logic [2:0] sel);
        case (sel)
            3'd0, 3'd1: return 3'b000;
            3'd2:       return 3'b111;
            3'd3:       return 3'b110;
            3'd4:       return 3'b100;
            default:    return 3'b010;
        endcase
    endfunction

    function automatic logic [63:0] rv_alu(input logic [2:0] f3, input logic sub,
                                           input logic [63:0] a, input logic [63:0] b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return {63'd0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 64'd0;
        endcase
    endfunction

    // addresses outside the program answer with a nop
    function automatic logic [31:0] imem_word(input logic [63:0] addr);
        logic [63:0] offset;
        offset = addr - `RESET_PC;
        if (addr < `RESET_PC || offset[1:0] != 2'b00 || (offset >> 2) >= 64'(PROG_LEN)) begin
            return NOP_WORD;
        end
        return prog[offset[9:2]];
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          span;
        int          hops;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            r    = $urandom;
            rd   = {2'b00, r[2:0]};     // x0..x7 keeps dependencies dense
            rs1  = {2'b00, r[5:3]};
            rs2  = {2'b00, r[8:6]};
            span = (PROG_LEN - 1 - i < 8) ? PROG_LEN - 1 - i : 8;
            hops = 1 + int'(r[31:29]) % span;   // forward only and never past the final jal
            if (i < 7) begin
                prog[8'(i)] = encode_i(r[31:20], 5'd0, 3'b000, 5'(i + 1));   // seed x1..x7
            end else begin
                case (r[12:9])
                    4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd15: begin
                        prog[8'(i)] = encode_r((r[15:13] == 3'd1) ? 7'b0100000 : 7'b0,
                                               rs2, rs1, pick_funct3(r[15:13]), rd);
                    end
                    4'd5, 4'd6, 4'd7, 4'd8, 4'd9: begin
                        prog[8'(i)] = encode_i(r[31:20], rs1, pick_funct3(r[15:13]), rd);
                    end
                    4'd10, 4'd11: prog[8'(i)] = encode_u(r[31:12], rd);
                    4'd12:        prog[8'(i)] = encode_j(21'(hops * 4), rd);
                    default: begin
                        prog[8'(i)] = encode_b(13'(hops * 4), rs2, rs1,
                                               r[13] ? 3'b001 : 3'b000);
                    end
                endcase
            end
        end
        prog[8'(PROG_LEN - 1)] = encode_j(21'd0, 5'd0);   // park on itself
    endtask

    // instruction memory answering one cycle after the strobe
    always @(negedge clk) begin
        fetch_instr_i <= pend_req ? imem_word(pend_addr) : NOP_WORD;
        pend_req      <= fetch_req_o;
        pend_addr     <= fetch_addr_o;
        if (fetch_req_o) begin
            fetched_once <= 1'b1;
        end
    end

    // ISA reference for the instruction at model_pc
    always_comb begin
        src_a       = model_regs[model_word[19:15]];
        src_b       = model_regs[model_word[24:20]];
        m_result    = 64'd0;
        m_writes    = 1'b0;
        exp_next_pc = model_pc + 64'd4;
        case (model_word[6:0])
            7'b0110011: begin
                m_result = rv_alu(model_word[14:12], model_word[30], src_a, src_b);
                m_writes = 1'b1;
            end
            7'b0010011: begin
                m_result = rv_alu(model_word[14:12], 1'b0, src_a,
                                  {{52{model_word[31]}}, model_word[31:20]});
                m_writes = 1'b1;
            end
            7'b0110111: begin
                m_result = {{32{model_word[31]}}, model_word[31:12], 12'b0};
                m_writes = 1'b1;
            end
            7'b1101111: begin
                m_result    = model_pc + 64'd4;
                m_writes    = 1'b1;
                exp_next_pc = model_pc + {{43{model_word[31]}}, model_word[31],
                              model_word[19:12], model_word[20], model_word[30:21], 1'b0};
            end
            7'b1100011: begin
                if ((model_word[14:12] == 3'b000) ? (src_a == src_b) : (src_a != src_b)) begin
                    exp_next_pc = model_pc + {{51{model_word[31]}}, model_word[31],
                                  model_word[7], model_word[30:25], model_word[11:8], 1'b0};
                end
            end
            default: begin
            end
        endcase
        exp_rd   = (m_writes && model_word[11:7] != 5'd0) ? model_word[11:7] : 5'd0;
        exp_data = (exp_rd != 5'd0) ? m_result : 64'd0;
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            model_pc     <= `RESET_PC;
            model_word   <= imem_word(`RESET_PC);
            model_regs   <= '{default: 64'd0};
            retire_count <= 0;
        end else if (retire_valid_o) begin
            model_pc     <= exp_next_pc;
            model_word   <= imem_word(exp_next_pc);
            retire_count <= retire_count + 1;
            if (exp_rd != 5'd0) begin
                model_regs[exp_rd] <= exp_data;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout after %0d cycles with only %0d retirements",
                                    cycle_count, retire_count));
        end
    end

    a_reset_quiet: assert property (@(negedge clk)
        !rst_n_i |-> !fetch_req_o && !retire_valid_o)
        else stop_on_error("fetch strobe or retirement seen while reset is held");

    a_first_fetch_pc: assert property (@(negedge clk) disable iff (!rst_n_i)
        (fetch_req_o && !fetched_once) |-> fetch_addr_o == `RESET_PC)
        else stop_on_error($sformatf("MISMATCH fetch_addr_o got %h expected %h",
                                     fetch_addr_o, `RESET_PC));

    a_retire_pc: assert property (@(negedge clk) disable iff (!rst_n_i)
        retire_valid_o |-> retire_pc_o == model_pc)
        else stop_on_error($sformatf("MISMATCH retire_pc_o got %h expected %h",
                                     retire_pc_o, model_pc));

    a_retire_rd: assert property (@(negedge clk) disable iff (!rst_n_i)
        retire_valid_o |-> retire_rd_o == exp_rd)
        else stop_on_error($sformatf("MISMATCH retire_rd_o got %h expected %h",
                                     retire_rd_o, exp_rd));

    a_retire_data: assert property (@(negedge clk) disable iff (!rst_n_i)
        retire_valid_o |-> retire_data_o == exp_data)
        else stop_on_error($sformatf("MISMATCH retire_data_o got %h expected %h",
                                     retire_data_o, exp_data));

    a_x0_reads_zero: assert property (@(negedge clk) disable iff (!rst_n_i)
        (retire_valid_o && retire_rd_o == 5'd0) |-> retire_data_o == 64'd0)
        else stop_on_error($sformatf("MISMATCH retire_data_o got %h expected %h for x0",
                                     retire_data_o, 64'd0));

    a_fetch_starts: assert property (@(negedge clk) $rose(rst_n_i) |-> fetch_req_o)
        else stop_on_error("no fetch strobe in the first cycle after reset");

    a_fetch_no_gap: assert property (@(negedge clk) disable iff (!rst_n_i)
        fetch_req_o |=> fetch_req_o)
        else stop_on_error("fetch strobe dropped after it had started");

    initial begin
        void'($urandom(32'ha1b44e24));
        rst_n_i = 1'b0;
        build_program();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        wait (retire_count >= NUM_RETIRE);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/core_pkg.sv
rtl/pipeline_ctrl.sv
rtl/fetch_unit.sv
decode/inst_decode.sv
decode/reg_file.sv
rtl/execute_unit.sv
rtl/core_top.sv
tests/tb_core_top.sv

// ==== Makefile ====
# Verilator build for the core testbench

VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := common/core_config.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG) || { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
